// ==== design/afifo_dpram.sv ====
`timescale 1ns/100ps
`default_nettype none

module afifo_dpram (
  input  logic             wr_clk,
  input  logic             wr_we,
  input  afifo_pkg::addr_t wr_addr,
  input  afifo_pkg::data_t wr_data,
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_re,
  input  afifo_pkg::addr_t rd_addr,
  output afifo_pkg::data_t rd_data
);

  afifo_pkg::data_t mem [afifo_pkg::DEPTH];

  // Entry has been written at least once
  logic [afifo_pkg::DEPTH-1:0] written = '0;

  always_ff @(posedge wr_clk) begin
    if (wr_we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_we) begin
      written[wr_addr] <= 1'b1;
    end
  end

  // Read register holds between accepted reads
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_re) begin
      rd_data <= mem[rd_addr];
    end
  end

  a_no_read_of_unwritten : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_re |-> written[rd_addr]
  ) else $error("afifo_dpram: read of never-written entry %0d", rd_addr);

endmodule

`default_nettype wire

// ==== design/afifo_pkg.sv ====
`default_nettype none

package afifo_pkg;

  localparam int DATA_W = 8;
  localparam int ADDR_W = 4;
  localparam int DEPTH  = 1 << ADDR_W;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Extra top bit is the wrap bit
  typedef logic [ADDR_W:0]   ptr_t;

  // Fill count 0..DEPTH
  typedef logic [ADDR_W:0]   level_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[ADDR_W] = gray[ADDR_W];
    // Each lower bit folds in everything above it
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// ==== design/afifo_ptr_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module afifo_ptr_sync (
  input  logic            clk,
  input  logic            rst_n,
  input  afifo_pkg::ptr_t gray_in,
  output afifo_pkg::ptr_t gray_sync
);

  afifo_pkg::ptr_t meta_q;
  afifo_pkg::ptr_t sync_q;

  // First stage may go metastable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gray_in;
      sync_q <= meta_q;
    end
  end

  assign gray_sync = sync_q;

  // Source may step up to twice between our edges when it runs faster
  a_gray_source : assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(gray_in ^ $past(gray_in)) <= 2
  ) else $error("afifo_ptr_sync: source pointer is not Gray coded");

endmodule

`default_nettype wire

// ==== design/afifo_rd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module afifo_rd_ctrl #(
  parameter afifo_pkg::level_t AEMPTY_LEVEL = afifo_pkg::level_t'(2)
) (
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_en,
  input  afifo_pkg::ptr_t  wr_gray_sync,
  output logic             rd_re,
  output afifo_pkg::addr_t rd_addr,
  output afifo_pkg::ptr_t  rd_gray,
  output logic             empty,
  output logic             aempty
);

  localparam int AW = afifo_pkg::ADDR_W;

  afifo_pkg::ptr_t   rd_bin;
  afifo_pkg::ptr_t   rd_bin_nxt;
  afifo_pkg::ptr_t   rd_gray_nxt;
  afifo_pkg::ptr_t   wr_bin_sync;
  afifo_pkg::level_t rd_level_nxt;
  logic              empty_nxt;
  logic              aempty_nxt;

  // Reads while empty are dropped
  assign rd_re = rd_en && !empty;

  assign rd_bin_nxt  = rd_bin + afifo_pkg::ptr_t'(rd_re);
  assign rd_gray_nxt = afifo_pkg::bin2gray(rd_bin_nxt);
  assign rd_addr     = rd_bin[AW-1:0];

  // Caught up with the synchronized write pointer
  assign empty_nxt = (rd_gray_nxt == wr_gray_sync);

  // Level left after this cycle's read
  assign wr_bin_sync  = afifo_pkg::gray2bin(wr_gray_sync);
  assign rd_level_nxt = afifo_pkg::level_t'(wr_bin_sync - rd_bin_nxt);
  assign aempty_nxt   = (rd_level_nxt <= AEMPTY_LEVEL);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // Comes out of reset empty
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

  a_rd_gray_step : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1
  ) else $error("afifo_rd_ctrl: rd_gray moved more than one bit");

  // Pointer distance before the read must hold a word
  a_no_read_when_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_re |-> (afifo_pkg::level_t'(wr_bin_sync - rd_bin) != '0)
  ) else $error("afifo_rd_ctrl: read accepted while empty");

endmodule

`default_nettype wire

// ==== design/afifo_wr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module afifo_wr_ctrl #(
  parameter afifo_pkg::level_t AFULL_LEVEL = afifo_pkg::level_t'(afifo_pkg::DEPTH - 2)
) (
  input  logic             wr_clk,
  input  logic             wr_rst_n,
  input  logic             wr_en,
  input  afifo_pkg::ptr_t  rd_gray_sync,
  output logic             wr_we,
  output afifo_pkg::addr_t wr_addr,
  output afifo_pkg::ptr_t  wr_gray,
  output logic             full,
  output logic             afull
);

  localparam int AW = afifo_pkg::ADDR_W;

  afifo_pkg::ptr_t   wr_bin;
  afifo_pkg::ptr_t   wr_bin_nxt;
  afifo_pkg::ptr_t   wr_gray_nxt;
  afifo_pkg::ptr_t   rd_bin_sync;
  afifo_pkg::ptr_t   rd_gray_full;
  afifo_pkg::level_t wr_level_nxt;
  logic              full_nxt;
  logic              afull_nxt;

  // Writes while full are dropped
  assign wr_we = wr_en && !full;

  assign wr_bin_nxt  = wr_bin + afifo_pkg::ptr_t'(wr_we);
  assign wr_gray_nxt = afifo_pkg::bin2gray(wr_bin_nxt);
  assign wr_addr     = wr_bin[AW-1:0];

  // Full pattern is the read pointer one lap behind
  assign rd_gray_full = {~rd_gray_sync[AW:AW-1], rd_gray_sync[AW-2:0]};
  assign full_nxt     = (wr_gray_nxt == rd_gray_full);

  // Level seen after this cycle's write
  assign rd_bin_sync  = afifo_pkg::gray2bin(rd_gray_sync);
  assign wr_level_nxt = afifo_pkg::level_t'(wr_bin_nxt - rd_bin_sync);
  assign afull_nxt    = (wr_level_nxt >= AFULL_LEVEL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

  a_wr_gray_step : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  ) else $error("afifo_wr_ctrl: wr_gray moved more than one bit");

  // Pointer distance before the write must leave a free entry
  a_no_write_when_full : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_we |-> (afifo_pkg::level_t'(wr_bin - rd_bin_sync) < afifo_pkg::DEPTH)
  ) else $error("afifo_wr_ctrl: write accepted while full");

endmodule

`default_nettype wire

// ==== design/async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo #(
  parameter afifo_pkg::level_t AFULL_LEVEL  = afifo_pkg::level_t'(afifo_pkg::DEPTH - 2),
  parameter afifo_pkg::level_t AEMPTY_LEVEL = afifo_pkg::level_t'(2)
) (
  input  logic             wr_clk,
  input  logic             wr_rst_n,
  input  logic             wr_en,
  input  afifo_pkg::data_t wr_data,
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_en,
  output afifo_pkg::data_t rd_data,
  output logic             full,
  output logic             afull,
  output logic             empty,
  output logic             aempty
);

  // Write domain
  logic             wr_we;
  afifo_pkg::addr_t wr_addr;
  afifo_pkg::ptr_t  wr_gray;
  afifo_pkg::ptr_t  rd_gray_sync;

  // Read domain
  logic             rd_re;
  afifo_pkg::addr_t rd_addr;
  afifo_pkg::ptr_t  rd_gray;
  afifo_pkg::ptr_t  wr_gray_sync;

  afifo_dpram u_dpram (
    .wr_clk   (wr_clk),
    .wr_we    (wr_we),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_re    (rd_re),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  afifo_wr_ctrl #(
    .AFULL_LEVEL (AFULL_LEVEL)
  ) u_wr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .wr_we        (wr_we),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  afifo_rd_ctrl #(
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .rd_re        (rd_re),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .empty        (empty),
    .aempty       (aempty)
  );

  // Write pointer into read domain
  afifo_ptr_sync u_wr2rd_sync (
    .clk       (rd_clk),
    .rst_n     (rd_rst_n),
    .gray_in   (wr_gray),
    .gray_sync (wr_gray_sync)
  );

  // Read pointer into write domain
  afifo_ptr_sync u_rd2wr_sync (
    .clk       (wr_clk),
    .rst_n     (wr_rst_n),
    .gray_in   (rd_gray),
    .gray_sync (rd_gray_sync)
  );

endmodule

`default_nettype wire

// ==== dv/tb_async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_async_fifo;

  localparam afifo_pkg::level_t AFULL_LEVEL  = afifo_pkg::level_t'(afifo_pkg::DEPTH - 2);
  localparam afifo_pkg::level_t AEMPTY_LEVEL = afifo_pkg::level_t'(2);
  localparam int RANDOM_CYCLES  = 400;
  localparam int TIMEOUT_CYCLES = 4000;

  logic             wr_clk;
  logic             wr_rst_n;
  logic             wr_en;
  afifo_pkg::data_t wr_data;
  logic             rd_clk;
  logic             rd_rst_n;
  logic             rd_en;
  afifo_pkg::data_t rd_data;
  logic             full;
  logic             afull;
  logic             empty;
  logic             aempty;

  // Reference model of the FIFO contents
  afifo_pkg::data_t model_q[$];

  logic [31:0]      lcg_state = 32'd88;
  logic             rd_pending = 1'b0;
  afifo_pkg::data_t rd_expect = '0;
  afifo_pkg::data_t rd_last = '0;
  int               err_count = 0;
  int               test_err_start = 0;
  int               tests_run = 0;
  int               tests_failed = 0;
  int               cycle_count = 0;

  async_fifo u_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever begin
      #20;
      rd_clk = ~rd_clk;
    end
  end

  // Faster write clock so the two domains drift
  initial begin
    wr_clk = 1'b0;
    forever begin
      #14;
      wr_clk = ~wr_clk;
    end
  end

  function automatic logic [31:0] next_lcg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic coin_flip();
    logic [31:0] r;
    r = next_lcg();
    return r[16];
  endfunction

  function automatic afifo_pkg::data_t random_word();
    logic [31:0] r;
    r = next_lcg();
    return r[27:20];
  endfunction

  function automatic int random_level();
    logic [31:0] r;
    r = next_lcg();
    return int'(r[31:16]) % (afifo_pkg::DEPTH + 1);
  endfunction

  task automatic check_data(input string name, input afifo_pkg::data_t got,
                            input afifo_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      err_count++;
    end
  endtask

  task automatic check_level(input string name, input afifo_pkg::level_t got,
                             input afifo_pkg::level_t max);
    if (got > max) begin
      $display("ERROR %s: got 0x%h above limit 0x%h at %0t", name, got, max, $time);
      err_count++;
    end
  endtask

  task automatic wait_wr_edge();
    @(posedge wr_clk);
    #2;
  endtask

  task automatic wait_rd_edge();
    @(posedge rd_clk);
    #2;
  endtask

  // Full is stable between write edges, so acceptance is known here
  task automatic drive_write(input logic strobe, input afifo_pkg::data_t word);
    wr_en   = strobe;
    wr_data = word;
    if (strobe && !full) begin
      model_q.push_back(word);
      check_level("model level", afifo_pkg::level_t'(model_q.size()),
                  afifo_pkg::level_t'(afifo_pkg::DEPTH));
    end
  endtask

  task automatic drive_read(input logic strobe);
    rd_en = strobe;
    if (strobe && !empty) begin
      if (model_q.size() == 0) begin
        $display("Read accepted while the model holds no words at %0t", $time);
        err_count++;
      end else begin
        rd_expect  = model_q.pop_front();
        rd_pending = 1'b1;
      end
    end
  endtask

  // Result of the strobe driven one edge earlier
  task automatic check_read_port();
    if (rd_pending) begin
      check_data("rd_data", rd_data, rd_expect);
      rd_last    = rd_expect;
      rd_pending = 1'b0;
    end else begin
      check_data("rd_data held", rd_data, rd_last);
    end
  endtask

  task automatic write_cycle(input logic strobe, input afifo_pkg::data_t word);
    wait_wr_edge();
    drive_write(strobe, word);
  endtask

  task automatic read_cycle(input logic strobe);
    wait_rd_edge();
    check_read_port();
    drive_read(strobe);
  endtask

  task automatic start_test();
    test_err_start = err_count;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count != test_err_start) begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, err_count - test_err_start);
    end else begin
      $display("%s: PASS", name);
    end
  endtask

  task automatic check_settled_flags();
    check_flag("full", full, model_q.size() == afifo_pkg::DEPTH);
    check_flag("empty", empty, model_q.size() == 0);
    check_flag("afull", afull, model_q.size() >= AFULL_LEVEL);
    check_flag("aempty", aempty, model_q.size() <= AEMPTY_LEVEL);
  endtask

  task automatic run_fill();
    afifo_pkg::data_t word;
    start_test();
    repeat (afifo_pkg::DEPTH + 3) begin
      wait_wr_edge();
      check_flag("full", full, model_q.size() >= afifo_pkg::DEPTH);
      check_flag("afull", afull, model_q.size() >= AFULL_LEVEL);
      word = random_word();
      drive_write(1'b1, word);
    end
    wait_wr_edge();
    check_flag("full", full, model_q.size() >= afifo_pkg::DEPTH);
    check_flag("afull", afull, model_q.size() >= AFULL_LEVEL);
    drive_write(1'b0, '0);
    if (model_q.size() != afifo_pkg::DEPTH) begin
      $display("Fill stored %0d words instead of %0d", model_q.size(), afifo_pkg::DEPTH);
      err_count++;
    end
    finish_test("fill");
  endtask

  task automatic run_drain();
    int extra;
    start_test();
    repeat (6) read_cycle(1'b0);
    extra = 0;
    // Keep reading until three strobes have hit an empty FIFO
    while (extra < 3) begin
      wait_rd_edge();
      check_read_port();
      check_flag("empty", empty, model_q.size() == 0);
      check_flag("aempty", aempty, model_q.size() <= AEMPTY_LEVEL);
      if (empty) begin
        extra++;
      end
      drive_read(1'b1);
    end
    read_cycle(1'b0);
    finish_test("drain");
  endtask

  task automatic run_random();
    logic             wr_bit;
    afifo_pkg::data_t wr_word;
    logic             rd_bit;
    start_test();
    fork
      begin
        repeat (RANDOM_CYCLES) begin
          wr_bit  = coin_flip();
          wr_word = random_word();
          write_cycle(wr_bit, wr_word);
        end
        write_cycle(1'b0, '0);
      end
      begin
        repeat (RANDOM_CYCLES) begin
          rd_bit = coin_flip();
          read_cycle(rd_bit);
        end
        read_cycle(1'b0);
      end
    join
    finish_test("random traffic");
  endtask

  task automatic run_settled();
    int               target;
    afifo_pkg::data_t word;
    start_test();
    repeat (6) begin
      target = random_level();
      while (model_q.size() < target) begin
        word = random_word();
        write_cycle(1'b1, word);
      end
      write_cycle(1'b0, '0);
      while (model_q.size() > target) begin
        read_cycle(1'b1);
      end
      read_cycle(1'b0);
      // Let both pointers cross over
      repeat (6) read_cycle(1'b0);
      check_settled_flags();
    end
    finish_test("settled flags");
  endtask

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge rd_clk);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d rd_clk cycles", cycle_count);
    $display("Test failures found");
    $finish;
  end

  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    repeat (2) @(posedge rd_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    start_test();
    wait_rd_edge();
    check_flag("full", full, 1'b0);
    check_flag("afull", afull, 1'b0);
    check_flag("empty", empty, 1'b1);
    check_flag("aempty", aempty, 1'b1);
    check_data("rd_data", rd_data, '0);
    finish_test("reset state");

    run_fill();
    run_drain();
    run_random();
    run_settled();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
design/afifo_pkg.sv
design/afifo_dpram.sv
design/afifo_ptr_sync.sv
design/afifo_wr_ctrl.sv
design/afifo_rd_ctrl.sv
design/async_fifo.sv
dv/tb_async_fifo.sv
